// ==== verilog/mem_pkg.sv ====
/* shared types and constants for the memory subsystem: address windows, memory
   actions, access sizes, request structs and the byte-lane write merge */
package mem_pkg;

  // address windows
  localparam logic [63:0] MEM_BASE = 64'h0000_0000_8000_0000;
  localparam logic [63:0] MEM_MASK = 64'hffff_ffff_f000_0000; // 256 MB
  localparam logic [63:0] DEV_BASE = 64'h0000_0000_2000_0000;
  localparam logic [63:0] DEV_MASK = 64'hffff_ffff_ffff_f000; // 4 KB

  // data cache model
  localparam int DCACHE_DEPTH   = 256; // doublewords
  localparam int DCACHE_IDX_W   = $clog2(DCACHE_DEPTH);
  localparam int DCACHE_LATENCY = 2;   // request rise to ack

  localparam int DEV_NREGS = 4;

  // funct3[1:0] size field
  localparam logic [1:0] F3_SIZE_B = 2'd0;
  localparam logic [1:0] F3_SIZE_H = 2'd1;
  localparam logic [1:0] F3_SIZE_W = 2'd2;
  localparam logic [1:0] F3_SIZE_D = 2'd3;

  // request byte counts, size minus one
  localparam logic [2:0] BYTES_B = 3'd0;
  localparam logic [2:0] BYTES_H = 3'd1;
  localparam logic [2:0] BYTES_W = 3'd3;
  localparam logic [2:0] BYTES_D = 3'd7;

  typedef enum logic [1:0] {
    MEM_ACTION_NONE,
    MEM_ACTION_LOAD,
    MEM_ACTION_STORE
  } mem_action_t;

  typedef struct packed {
    mem_action_t action;
    logic [2:0]  funct3;
    logic [63:0] addr;
    logic [63:0] wdata;
  } ex_to_mem_t;

  typedef struct packed {
    logic        write;
    logic [63:0] addr;
    logic [2:0]  bytes;
    logic [63:0] wdata; // already in its byte lane
  } mem_req_t;

  // replace only the lanes picked by size and offset
  function automatic logic [63:0] merge_lanes(input logic [63:0] old, input mem_req_t req);
    logic [7:0]  lanes;
    logic [63:0] merged;
    lanes  = (8'hff >> (3'd7 - req.bytes)) << req.addr[2:0];
    merged = old;
    for (int i = 0; i < 8; i++) begin
      if (lanes[i]) begin
        merged[i*8 +: 8] = req.wdata[i*8 +: 8];
      end
    end
    return merged;
  endfunction

endpackage

// ==== verilog/mem_stage.sv ====
`timescale 1ns/1ps
/* memory-access stage: window decode, request launch to cache or devices,
   completion handshake, load alignment and sign/zero extension */
module mem_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_ena,
  input  logic                i_executed_req,
  input  mem_pkg::ex_to_mem_t i_ex,
  input  logic                i_memoryed_ack,
  input  logic                i_dcache_ack,
  input  logic [63:0]         i_dcache_rdata,
  input  logic                i_dev_ack,
  input  logic [63:0]         i_dev_rdata,
  output logic                o_memoryed_req,
  output logic [63:0]         o_rdata,
  output logic                o_dcache_req,
  output logic                o_dev_req,
  output mem_pkg::mem_req_t   o_req
);
  import mem_pkg::*;

  mem_action_t action;
  logic        is_mem;
  logic        is_dev;
  logic        is_load;
  logic        is_store;
  logic [2:0]  bytes;
  logic [5:0]  lane_shift;
  logic        ld_unsigned;
  logic        hs;
  logic [63:0] ack_data;
  logic [63:0] shifted;
  logic [63:0] ld_value;

  assign action   = i_ena ? i_ex.action : MEM_ACTION_NONE; // disabled stage does nothing
  assign is_mem   = (i_ex.addr & MEM_MASK) == MEM_BASE;
  assign is_dev   = (i_ex.addr & DEV_MASK) == DEV_BASE;
  assign is_load  = action == MEM_ACTION_LOAD;
  assign is_store = action == MEM_ACTION_STORE;
  assign lane_shift = {i_ex.addr[2:0], 3'b000};

  always_comb begin
    case (i_ex.funct3[1:0])
      F3_SIZE_B: bytes = BYTES_B;
      F3_SIZE_H: bytes = BYTES_H;
      F3_SIZE_W: bytes = BYTES_W;
      F3_SIZE_D: bytes = BYTES_D;
    endcase
  end

  // only the addressed target can ack
  assign hs       = (o_dcache_req & i_dcache_ack) | (o_dev_req & i_dev_ack);
  assign ack_data = o_dcache_req ? i_dcache_rdata : i_dev_rdata;
  assign shifted  = ack_data >> {o_req.addr[2:0], 3'b000};

  always_comb begin
    case (o_req.bytes)
      BYTES_B: ld_value = ld_unsigned ? {56'd0, shifted[7:0]} :
                                        {{56{shifted[7]}}, shifted[7:0]};
      BYTES_H: ld_value = ld_unsigned ? {48'd0, shifted[15:0]} :
                                        {{48{shifted[15]}}, shifted[15:0]};
      BYTES_W: ld_value = ld_unsigned ? {32'd0, shifted[31:0]} :
                                        {{32{shifted[31]}}, shifted[31:0]};
      default: ld_value = shifted;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_memoryed_req <= 1'b0;
      o_dcache_req   <= 1'b0;
      o_dev_req      <= 1'b0;
      o_rdata        <= '0;
    end else begin
      if (i_memoryed_ack) begin
        o_memoryed_req <= 1'b0;
      end
      if (i_executed_req) begin
        if ((is_load || is_store) && (is_mem || is_dev)) begin
          o_dcache_req <= is_mem;
          o_dev_req    <= is_dev;
        end else begin
          o_memoryed_req <= 1'b1; // done at once
          if (is_load) begin
            o_rdata <= '0; // unmapped load
          end
        end
      end else if (hs) begin
        o_dcache_req   <= 1'b0;
        o_dev_req      <= 1'b0;
        o_memoryed_req <= 1'b1;
        if (!o_req.write) begin
          o_rdata <= ld_value;
        end
      end
    end
  end

  // request payload, held until the next instruction
  always_ff @(posedge clk) begin
    if (i_executed_req) begin
      o_req.write <= is_store;
      o_req.addr  <= i_ex.addr;
      o_req.bytes <= bytes;
      o_req.wdata <= i_ex.wdata << lane_shift;
      ld_unsigned <= i_ex.funct3[2];
    end
  end

endmodule

// ==== verilog/dcache.sv ====
`timescale 1ns/1ps
/* data cache model: doubleword array with byte-masked writes and a fixed
   DCACHE_LATENCY acknowledge */
module dcache (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_req,
  input  mem_pkg::mem_req_t i_cmd,
  output logic              o_ack,
  output logic [63:0]       o_rdata
);
  import mem_pkg::*;

  logic [63:0]             mem [DCACHE_DEPTH];
  logic [DCACHE_IDX_W-1:0] idx;
  logic [1:0]              cnt;
  logic                    served; // current request already acked
  logic                    fire;

  assign idx  = i_cmd.addr[DCACHE_IDX_W+2:3];
  assign fire = i_req && !served && (cnt == 2'(DCACHE_LATENCY - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt    <= '0;
      served <= 1'b0;
      o_ack  <= 1'b0;
    end else begin
      o_ack <= fire;
      if (!i_req) begin
        cnt    <= '0;
        served <= 1'b0;
      end else if (fire) begin
        cnt    <= '0;
        served <= 1'b1;
      end else if (!served) begin
        cnt <= cnt + 2'd1;
      end
    end
  end

  // access happens in the cycle before the ack
  always_ff @(posedge clk) begin
    if (fire) begin
      o_rdata <= mem[idx];
      if (i_cmd.write) begin
        mem[idx] <= merge_lanes(mem[idx], i_cmd);
      end
    end
  end

endmodule

// ==== verilog/devices.sv ====
`timescale 1ns/1ps
/* device block: four 64-bit scratch registers with a one-cycle acknowledge */
module devices (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_req,
  input  mem_pkg::mem_req_t i_cmd,
  output logic              o_ack,
  output logic [63:0]       o_rdata
);
  import mem_pkg::*;

  logic [63:0] scratch [DEV_NREGS];
  logic [1:0]  sel;
  logic        fire;

  assign sel  = i_cmd.addr[4:3];
  assign fire = i_req && !o_ack; // stage drops req right after ack

  always_ff @(posedge clk) begin
    if (rst) begin
      o_ack <= 1'b0;
      for (int i = 0; i < DEV_NREGS; i++) begin
        scratch[i] <= '0;
      end
    end else begin
      o_ack <= fire;
      if (fire && i_cmd.write) begin
        scratch[sel] <= merge_lanes(scratch[sel], i_cmd);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      o_rdata <= scratch[sel]; // whole register
    end
  end

endmodule

// ==== verilog/mem_subsys_top.sv ====
`timescale 1ns/1ps
/* memory subsystem top: stage, data cache model and device block */
module mem_subsys_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_ena,
  input  logic                i_executed_req,
  input  mem_pkg::ex_to_mem_t i_ex,
  input  logic                i_memoryed_ack,
  output logic                o_memoryed_req,
  output logic [63:0]         o_rdata
);
  import mem_pkg::*;

  mem_req_t    req; // shared by both targets
  logic        dcache_req;
  logic        dcache_ack;
  logic [63:0] dcache_rdata;
  logic        dev_req;
  logic        dev_ack;
  logic [63:0] dev_rdata;

  mem_stage u_mem_stage (
    .clk            (clk),
    .rst            (rst),
    .i_ena          (i_ena),
    .i_executed_req (i_executed_req),
    .i_ex           (i_ex),
    .i_memoryed_ack (i_memoryed_ack),
    .i_dcache_ack   (dcache_ack),
    .i_dcache_rdata (dcache_rdata),
    .i_dev_ack      (dev_ack),
    .i_dev_rdata    (dev_rdata),
    .o_memoryed_req (o_memoryed_req),
    .o_rdata        (o_rdata),
    .o_dcache_req   (dcache_req),
    .o_dev_req      (dev_req),
    .o_req          (req)
  );

  dcache u_dcache (
    .clk     (clk),
    .rst     (rst),
    .i_req   (dcache_req),
    .i_cmd   (req),
    .o_ack   (dcache_ack),
    .o_rdata (dcache_rdata)
  );

  devices u_devices (
    .clk     (clk),
    .rst     (rst),
    .i_req   (dev_req),
    .i_cmd   (req),
    .o_ack   (dev_ack),
    .o_rdata (dev_rdata)
  );

endmodule

// ==== bench/tb_mem_subsys.sv ====
`timescale 1ns/1ps
/* memory subsystem testbench with reference model, stimulus table,
   table-driven run loop, checks and summary */
module tb_mem_subsys;
  import mem_pkg::*;

  localparam int DONE_TIMEOUT = DCACHE_LATENCY + 8; // cycles allowed for o_memoryed_req

  // funct3 encodings where loads and stores share the size bits
  localparam logic [2:0] F3_B  = 3'd0;
  localparam logic [2:0] F3_H  = 3'd1;
  localparam logic [2:0] F3_W  = 3'd2;
  localparam logic [2:0] F3_D  = 3'd3;
  localparam logic [2:0] F3_BU = 3'd4;
  localparam logic [2:0] F3_HU = 3'd5;
  localparam logic [2:0] F3_WU = 3'd6;

  typedef struct packed {
    logic        ena;
    ex_to_mem_t  ex;
    int          delay;   // cycles before i_memoryed_ack
    int          latency; // expected cycles to o_memoryed_req
    logic [63:0] exp_rdata;
  } entry_t;

  logic        clk;
  logic        rst;
  logic        i_ena;
  logic        i_executed_req;
  ex_to_mem_t  i_ex;
  logic        i_memoryed_ack;
  logic        o_memoryed_req;
  logic [63:0] o_rdata;

  entry_t      stim[$];
  logic [63:0] cache_ref [DCACHE_DEPTH];
  logic [63:0] dev_ref [4];
  logic [63:0] last_rdata;
  integer      seed;
  int          fail_count;
  int          entry_fails;
  bit          timed_out;

  mem_subsys_top DUT (
    .clk            (clk),
    .rst            (rst),
    .i_ena          (i_ena),
    .i_executed_req (i_executed_req),
    .i_ex           (i_ex),
    .i_memoryed_ack (i_memoryed_ack),
    .o_memoryed_req (o_memoryed_req),
    .o_rdata        (o_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic string action_label(input mem_action_t a);
    case (a)
      MEM_ACTION_LOAD:  return "load ";
      MEM_ACTION_STORE: return "store";
      default:          return "none ";
    endcase
  endfunction

  // reference model that computes the expected result and queues the entry
  task automatic add_entry(input logic ena, input mem_action_t act, input logic [2:0] f3,
                           input logic [63:0] addr, input logic [63:0] wdata, input int delay);
    entry_t      e;
    mem_action_t eff;
    logic [63:0] word;
    logic        in_cache;
    logic        in_dev;
    int          idx;
    int          didx;
    int          off;
    int          nbytes;
    int          sh;
    eff      = ena ? act : MEM_ACTION_NONE;
    in_cache = (addr & MEM_MASK) == MEM_BASE;
    in_dev   = (addr & DEV_MASK) == DEV_BASE;
    idx      = int'((addr >> 3) % DCACHE_DEPTH);
    didx     = int'(addr[4:3]);
    off      = int'(addr[2:0]);
    nbytes   = 1 << f3[1:0];
    word     = in_cache ? cache_ref[idx] : dev_ref[didx];
    e.latency = 1;
    if (eff != MEM_ACTION_NONE && (in_cache || in_dev)) begin
      e.latency = in_cache ? DCACHE_LATENCY + 2 : 3;
    end
    if (eff == MEM_ACTION_STORE && (in_cache || in_dev)) begin
      for (int i = 0; i < nbytes; i++) begin
        word[(off + i) * 8 +: 8] = wdata[i * 8 +: 8];
      end
      if (in_cache) cache_ref[idx] = word;
      else dev_ref[didx] = word;
    end else if (eff == MEM_ACTION_LOAD) begin
      if (!(in_cache || in_dev)) word = '0; // unmapped reads zero
      sh   = 64 - 8 * nbytes;
      word = (word >> (off * 8)) << sh;
      if (f3[2]) word = word >> sh;
      else word = $signed(word) >>> sh;
      last_rdata = word;
    end
    e.ena       = ena;
    e.ex.action = act;
    e.ex.funct3 = f3;
    e.ex.addr   = addr;
    e.ex.wdata  = wdata;
    e.delay     = delay;
    e.exp_rdata = last_rdata;
    stim.push_back(e);
  endtask

  task automatic build_table();
    logic [63:0] r1;
    logic [63:0] r2;
    logic [63:0] r3;
    logic [63:0] r4;
    logic [63:0] top_dw;
    r1 = {$random(seed), $random(seed)};
    r2 = {$random(seed), $random(seed)};
    r3 = {$random(seed), $random(seed)};
    r4 = {$random(seed), $random(seed)};
    top_dw = MEM_BASE + 64'((DCACHE_DEPTH - 1) * 8); // last cache entry
    // doubleword store and load back
    add_entry(1'b1, MEM_ACTION_STORE, F3_D, MEM_BASE + 64'h40, r1, 0);
    add_entry(1'b1, MEM_ACTION_LOAD, F3_D, MEM_BASE + 64'h40, '0, 1);
    // sub-word stores around an untouched lane 4
    add_entry(1'b1, MEM_ACTION_STORE, F3_B, MEM_BASE + 64'h45, 64'hdead_beef_cafe_01a5, 0);
    add_entry(1'b1, MEM_ACTION_STORE, F3_H, MEM_BASE + 64'h46, 64'h1111_2222_3333_8001, 2);
    add_entry(1'b1, MEM_ACTION_STORE, F3_W, MEM_BASE + 64'h40, 64'h4444_5555_f00d_beef, 0);
    add_entry(1'b1, MEM_ACTION_LOAD, F3_D, MEM_BASE + 64'h40, '0, 0);
    add_entry(1'b1, MEM_ACTION_LOAD, F3_B, MEM_BASE + 64'h45, '0, 0);
    add_entry(1'b1, MEM_ACTION_LOAD, F3_BU, MEM_BASE + 64'h45, '0, 0);
    add_entry(1'b1, MEM_ACTION_LOAD, F3_B, MEM_BASE + 64'h44, '0, 0);
    add_entry(1'b1, MEM_ACTION_LOAD, F3_H, MEM_BASE + 64'h46, '0, 0);
    add_entry(1'b1, MEM_ACTION_LOAD, F3_HU, MEM_BASE + 64'h46, '0, 1);
    add_entry(1'b1, MEM_ACTION_LOAD, F3_W, MEM_BASE + 64'h40, '0, 0);
    add_entry(1'b1, MEM_ACTION_LOAD, F3_WU, MEM_BASE + 64'h40, '0, 0);
    add_entry(1'b1, MEM_ACTION_STORE, F3_D, top_dw, r2, 0);
    add_entry(1'b1, MEM_ACTION_LOAD, F3_W, top_dw + 64'h4, '0, 0);
    add_entry(1'b1, MEM_ACTION_LOAD, F3_D, top_dw, '0, 0);
    // device registers vs cache at the same low bits
    add_entry(1'b1, MEM_ACTION_STORE, F3_D, MEM_BASE + 64'h8, r3, 0);
    add_entry(1'b1, MEM_ACTION_STORE, F3_D, DEV_BASE + 64'h8, r4, 0);
    add_entry(1'b1, MEM_ACTION_STORE, F3_D, DEV_BASE + 64'h10, 64'h0123_4567_89ab_cdef, 0);
    add_entry(1'b1, MEM_ACTION_STORE, F3_B, DEV_BASE + 64'h12, 64'h0000_0000_0000_007f, 0);
    add_entry(1'b1, MEM_ACTION_LOAD, F3_D, DEV_BASE + 64'h18, '0, 0); // still at reset
    add_entry(1'b1, MEM_ACTION_LOAD, F3_D, DEV_BASE + 64'h8, '0, 0);
    add_entry(1'b1, MEM_ACTION_LOAD, F3_D, DEV_BASE + 64'h10, '0, 0);
    add_entry(1'b1, MEM_ACTION_LOAD, F3_B, DEV_BASE + 64'h12, '0, 0);
    add_entry(1'b1, MEM_ACTION_LOAD, F3_HU, DEV_BASE + 64'h16, '0, 0);
    add_entry(1'b1, MEM_ACTION_LOAD, F3_D, MEM_BASE + 64'h8, '0, 0);
    // no-op, disabled stage and unmapped addresses
    add_entry(1'b1, MEM_ACTION_NONE, F3_D, MEM_BASE + 64'h40, '0, 0);
    add_entry(1'b0, MEM_ACTION_LOAD, F3_D, DEV_BASE + 64'h8, '0, 0);
    add_entry(1'b0, MEM_ACTION_STORE, F3_D, DEV_BASE + 64'h8, 64'h0bad_0bad_0bad_0bad, 0);
    add_entry(1'b1, MEM_ACTION_LOAD, F3_D, DEV_BASE + 64'h8, '0, 0);
    add_entry(1'b1, MEM_ACTION_STORE, F3_D, 64'h0000_0000_1000_0000, r1, 0);
    add_entry(1'b1, MEM_ACTION_LOAD, F3_D, 64'h0000_0000_1000_0000, '0, 0);
    add_entry(1'b1, MEM_ACTION_LOAD, F3_W, MEM_BASE + 64'h40, '0, 0);
    add_entry(1'b1, MEM_ACTION_LOAD, F3_W, 64'h4000_0000_8000_0040, '0, 0);
    // late completion ack and then a normal access
    add_entry(1'b1, MEM_ACTION_LOAD, F3_D, MEM_BASE + 64'h40, '0, 12);
    add_entry(1'b1, MEM_ACTION_LOAD, F3_H, DEV_BASE + 64'h10, '0, 0);
  endtask

  task automatic apply_entry(input int n, input entry_t e);
    int cycles;
    int fails_before;
    fails_before = fail_count;
    @(posedge clk);
    i_ena          <= e.ena;
    i_ex           <= e.ex;
    i_executed_req <= 1'b1;
    @(posedge clk);
    i_executed_req <= 1'b0;
    cycles = 1;
    @(negedge clk);
    while (!o_memoryed_req && cycles < DONE_TIMEOUT) begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
    end
    if (!o_memoryed_req) begin
      $display("entry %0d: gave up waiting for o_memoryed_req after %0d cycles", n, cycles);
      timed_out = 1'b1;
    end else begin
      assert (cycles == e.latency) else begin
        $display("FAIL %0t: entry %0d took %0d cycles, expected %0d",
                 $time, n, cycles, e.latency);
        fail_count++;
      end
      assert (o_rdata == e.exp_rdata) else begin
        $display("FAIL %0t: entry %0d o_rdata %h, expected %h", $time, n, o_rdata, e.exp_rdata);
        fail_count++;
      end
      for (int i = 0; i < e.delay; i++) begin
        @(posedge clk);
        @(negedge clk);
        assert (o_memoryed_req) else begin
          $display("FAIL %0t: entry %0d o_memoryed_req dropped before ack", $time, n);
          fail_count++;
        end
      end
      @(posedge clk);
      i_memoryed_ack <= 1'b1;
      @(posedge clk);
      i_memoryed_ack <= 1'b0;
      @(negedge clk);
      assert (!o_memoryed_req) else begin
        $display("FAIL %0t: entry %0d o_memoryed_req still high after ack", $time, n);
        fail_count++;
      end
      if (fail_count != fails_before) entry_fails++;
      $display("entry %0d: %s ena %b addr %h rdata %h latency %0d %s", n,
               action_label(e.ex.action), e.ena, e.ex.addr, o_rdata, cycles,
               (fail_count == fails_before) ? "ok" : "wrong");
    end
  endtask

  initial begin
    seed           = 16;
    fail_count     = 0;
    entry_fails    = 0;
    timed_out      = 1'b0;
    last_rdata     = '0; // o_rdata after reset
    rst            = 1'b1;
    i_ena          = 1'b0;
    i_executed_req = 1'b0;
    i_ex           = '0;
    i_memoryed_ack = 1'b0;
    for (int i = 0; i < DCACHE_DEPTH; i++) cache_ref[i] = '0;
    for (int i = 0; i < 4; i++) dev_ref[i] = '0;
    build_table();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    for (int n = 0; n < stim.size() && !timed_out; n++) begin
      apply_entry(n, stim[n]);
    end
    $display("%0d entries, %0d with errors, %0d check failures, timeout %0d",
             stim.size(), entry_fails, fail_count, timed_out);
    if (timed_out || fail_count != 0) begin
      $display("*** FAILED ***");
    end else begin
      $display("*** PASSED ***");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
verilog/mem_pkg.sv
verilog/mem_stage.sv
verilog/dcache.sv
verilog/devices.sv
verilog/mem_subsys_top.sv
bench/tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f filelist.f --top-module tb_mem_subsys -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -qF '*** PASSED ***' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
